/* logic/fpu_pkg.sv */
// shared widths, exponent bias and word/field types of the fpu
// opcode enum and command controller state enum
`default_nettype none

package fpu_pkg;

  // ieee-754 single precision field widths
  localparam int EXP_BIAS = 127;
  localparam int EXP_W    = 8;
  localparam int FRAC_W   = 23;
  // stored fraction plus the hidden bit
  localparam int MANT_W   = 24;
  // mantissa plus carry bit at 24 plus sign bit at 25
  localparam int WIDE_W   = 26;

  // full packed word: sign, biased exponent, fraction
  typedef logic [31:0] word_t;

  // biased exponent field
  typedef logic [EXP_W-1:0] exp_t;

  // mantissa with hidden bit at the top
  typedef logic [MANT_W-1:0] mant_t;

  // two's complement working value of the adder
  typedef logic signed [WIDE_W-1:0] wide_mant_t;

  // operations understood by the engine
  typedef enum logic [1:0] {
    op_add = 2'd0,
    op_sub = 2'd1,
    op_mul = 2'd2
  } fpu_op_t;

  // command sequencing
  // st_compute is the single cycle in which the unit results are captured
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_compute = 2'd1,
    st_done    = 2'd2
  } ctrl_state_t;

endpackage

`default_nettype wire

/* logic/fpu_operand_if.sv */
// unpacked operand fields and registered opcode
// src side is the unpack stage, dst side the arithmetic and output stages
`timescale 1ns/100ps
`default_nettype none

interface fpu_operand_if;

  // operand a
  logic                 a_sign;
  fpu_pkg::exp_t        a_exp;
  fpu_pkg::mant_t       a_mant;
  // operand b
  logic                 b_sign;
  fpu_pkg::exp_t        b_exp;
  fpu_pkg::mant_t       b_mant;
  // operation of the command in flight
  fpu_pkg::fpu_op_t     op;

  modport src (
    output a_sign, a_exp, a_mant,
    output b_sign, b_exp, b_mant,
    output op
  );

  modport dst (
    input a_sign, a_exp, a_mant,
    input b_sign, b_exp, b_mant,
    input op
  );

endinterface

`default_nettype wire

/* logic/fpu_cmd_ctrl.sv */
// command controller fsm of the fpu
// sequences one command: load, capture, then wait for start to drop
`timescale 1ns/100ps
`default_nettype none

module fpu_cmd_ctrl (
  input  logic clk,
  input  logic arst,
  input  logic start,
  output logic load,
  output logic capture,
  output logic busy,
  output logic cmd_end
);

  fpu_pkg::ctrl_state_t state;
  fpu_pkg::ctrl_state_t next_state;

  // state register
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      state <= fpu_pkg::st_idle;
    end else begin
      state <= next_state;
    end
  end

  // next state
  always_comb begin
    next_state = state;
    case (state)
      fpu_pkg::st_idle: begin
        // operands are sampled in this same cycle
        if (start) begin
          next_state = fpu_pkg::st_compute;
        end
      end
      fpu_pkg::st_compute: begin
        // units are combinational, one cycle is enough
        next_state = fpu_pkg::st_done;
      end
      fpu_pkg::st_done: begin
        // hold the end level until the host releases start
        if (!start) begin
          next_state = fpu_pkg::st_idle;
        end
      end
      default: begin
        next_state = fpu_pkg::st_idle;
      end
    endcase
  end

  // operand load strobe, only accepted while idle
  assign load    = (state == fpu_pkg::st_idle) && start;
  // result register write strobe
  assign capture = (state == fpu_pkg::st_compute);
  // status levels toward the host
  assign busy    = (state != fpu_pkg::st_idle);
  assign cmd_end = (state == fpu_pkg::st_done);

endmodule

`default_nettype wire

/* logic/fpu_unpack.sv */
// input side of the fpu
// registers the opcode and splits both operands into sign, exponent, mantissa
`timescale 1ns/100ps
`default_nettype none

module fpu_unpack (
  input  logic              clk,
  input  logic              arst,
  input  logic              load,
  input  fpu_pkg::fpu_op_t  op_in,
  input  fpu_pkg::word_t    a_operand,
  input  fpu_pkg::word_t    b_operand,
  fpu_operand_if.src        opnd
);

  // opcode register
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      opnd.op <= fpu_pkg::op_add;
    end else if (load) begin
      opnd.op <= op_in;
    end
  end

  // operand field registers
  // hidden bit is one for any nonzero exponent, zero for exact zero
  always_ff @(posedge clk) begin
    if (load) begin
      opnd.a_sign <= a_operand[31];
      opnd.a_exp  <= a_operand[30:23];
      opnd.a_mant <= {|a_operand[30:23], a_operand[fpu_pkg::FRAC_W-1:0]};
      opnd.b_sign <= b_operand[31];
      opnd.b_exp  <= b_operand[30:23];
      opnd.b_mant <= {|b_operand[30:23], b_operand[fpu_pkg::FRAC_W-1:0]};
    end
  end

endmodule

`default_nettype wire

/* logic/fpu_add_sub.sv */
// add/sub unit of the fpu
// alignment, signed mantissa add or subtract, normalization
`timescale 1ns/100ps
`default_nettype none

module fpu_add_sub (
  fpu_operand_if.dst       opnd,
  output fpu_pkg::word_t   add_result
);

  fpu_pkg::mant_t      a_align;
  fpu_pkg::mant_t      b_align;
  fpu_pkg::exp_t       exp_big;
  fpu_pkg::wide_mant_t a_ext;
  fpu_pkg::wide_mant_t b_ext;
  fpu_pkg::wide_mant_t a_tc;
  fpu_pkg::wide_mant_t b_tc;
  fpu_pkg::wide_mant_t sum;
  fpu_pkg::wide_mant_t mag;
  fpu_pkg::wide_mant_t mag_shl;
  logic                res_sign;
  logic [4:0]          lz;

  // alignment
  // smaller operand shifts right, lost bits are truncated
  always_comb begin
    if (opnd.a_exp < opnd.b_exp) begin
      a_align = opnd.a_mant >> (opnd.b_exp - opnd.a_exp);
      b_align = opnd.b_mant;
      exp_big = opnd.b_exp;
    end else begin
      a_align = opnd.a_mant;
      b_align = opnd.b_mant >> (opnd.a_exp - opnd.b_exp);
      exp_big = opnd.a_exp;
    end
  end

  // two guard bits on top: carry at 24, sign at 25
  assign a_ext = {2'b00, a_align};
  assign b_ext = {2'b00, b_align};
  assign a_tc  = opnd.a_sign ? -a_ext : a_ext;
  assign b_tc  = opnd.b_sign ? -b_ext : b_ext;

  assign sum      = (opnd.op == fpu_pkg::op_sub) ? a_tc - b_tc : a_tc + b_tc;
  assign res_sign = sum[fpu_pkg::WIDE_W-1];
  // magnitude always fits below the sign bit
  assign mag      = res_sign ? -sum : sum;

  // leading zeros below bit 23, highest set bit wins
  always_comb begin
    lz = 5'd0;
    for (int i = 0; i < fpu_pkg::MANT_W; i++) begin
      if (mag[i]) begin
        lz = 5'(fpu_pkg::MANT_W - 1 - i);
      end
    end
  end

  assign mag_shl = mag << lz;

  // normalization and packing
  always_comb begin
    if (mag == '0) begin
      // exact cancellation or zero inputs
      add_result = '0;
    end else if (mag[fpu_pkg::MANT_W]) begin
      // carry out of bit 23, one step right
      add_result = {res_sign, exp_big + 8'd1, mag[fpu_pkg::FRAC_W:1]};
    end else begin
      // cancellation, shift left and lower exponent by the full count
      add_result = {res_sign, exp_big - fpu_pkg::exp_t'(lz),
                    mag_shl[fpu_pkg::FRAC_W-1:0]};
    end
  end

endmodule

`default_nettype wire

/* logic/fpu_mul.sv */
// multiply unit of the fpu
// 24x24 mantissa product, exponent sum, round to nearest even
`timescale 1ns/100ps
`default_nettype none

module fpu_mul (
  fpu_operand_if.dst       opnd,
  output fpu_pkg::word_t   mul_result
);

  logic [2*fpu_pkg::MANT_W-1:0] product;
  logic [2*fpu_pkg::MANT_W-1:0] prod_norm;
  fpu_pkg::exp_t                exp_sum;
  fpu_pkg::exp_t                exp_norm;
  fpu_pkg::exp_t                exp_final;
  fpu_pkg::mant_t               mant_pre;
  fpu_pkg::mant_t               mant_final;
  logic [fpu_pkg::MANT_W:0]     mant_rnd;
  logic                         guard;
  logic                         sticky;
  logic                         round_up;
  logic                         res_sign;

  // unsigned mantissa product, value in [1, 4)
  assign product  = opnd.a_mant * opnd.b_mant;
  assign res_sign = opnd.a_sign ^ opnd.b_sign;

  // biased sum, wraps modulo 256 in between
  assign exp_sum = opnd.a_exp + opnd.b_exp - fpu_pkg::exp_t'(fpu_pkg::EXP_BIAS);

  // product at or above 2 keeps its top bit as the hidden bit
  // otherwise shift left one so bit 47 is always the hidden bit
  assign prod_norm = product[2*fpu_pkg::MANT_W-1] ? product : product << 1;
  assign exp_norm  = product[2*fpu_pkg::MANT_W-1] ? exp_sum + 8'd1 : exp_sum;

  // kept mantissa, first dropped bit and or of the rest
  assign mant_pre = prod_norm[2*fpu_pkg::MANT_W-1:fpu_pkg::MANT_W];
  assign guard    = prod_norm[fpu_pkg::MANT_W-1];
  assign sticky   = |prod_norm[fpu_pkg::MANT_W-2:0];

  // above half rounds up, exact half rounds to even lsb
  assign round_up = guard && (sticky || mant_pre[0]);
  assign mant_rnd = {1'b0, mant_pre} + (fpu_pkg::MANT_W+1)'(round_up);

  // rounding carry only from an all-ones mantissa
  // result is then 1.000... one exponent step up
  always_comb begin
    if (mant_rnd[fpu_pkg::MANT_W]) begin
      mant_final = mant_rnd[fpu_pkg::MANT_W:1];
      exp_final  = exp_norm + 8'd1;
    end else begin
      mant_final = mant_rnd[fpu_pkg::MANT_W-1:0];
      exp_final  = exp_norm;
    end
  end

  // hidden bit is dropped on packing
  assign mul_result = {res_sign, exp_final, mant_final[fpu_pkg::FRAC_W-1:0]};

endmodule

`default_nettype wire

/* logic/fpu_result_pack.sv */
// output side of the fpu
// selects the unit result by opcode and holds it in the result register
`timescale 1ns/100ps
`default_nettype none

module fpu_result_pack (
  input  logic            clk,
  input  logic            arst,
  input  logic            capture,
  fpu_operand_if.dst      opnd,
  input  fpu_pkg::word_t  add_result,
  input  fpu_pkg::word_t  mul_result,
  output fpu_pkg::word_t  result
);

  fpu_pkg::word_t sel_result;

  // add and sub share one unit
  assign sel_result = (opnd.op == fpu_pkg::op_mul) ? mul_result : add_result;

  // result register, holds until the next command is captured
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      result <= '0;
    end else if (capture) begin
      result <= sel_result;
    end
  end

endmodule

`default_nettype wire

/* logic/fpu_top.sv */
// top level of the fpu command engine
// controller, operand unpack, add/sub and multiply units, result register
`timescale 1ns/100ps
`default_nettype none

module fpu_top (
  input  logic              clk,
  input  logic              arst,
  input  logic              start,
  input  fpu_pkg::fpu_op_t  op,
  input  fpu_pkg::word_t    a_operand,
  input  fpu_pkg::word_t    b_operand,
  output fpu_pkg::word_t    result,
  output logic              busy,
  output logic              cmd_end
);

  logic           load;
  logic           capture;
  fpu_pkg::word_t add_result;
  fpu_pkg::word_t mul_result;

  // registered operand fields shared by units and output side
  fpu_operand_if u_opnd_if ();

  fpu_cmd_ctrl u_cmd_ctrl (
    .clk     (clk),
    .arst    (arst),
    .start   (start),
    .load    (load),
    .capture (capture),
    .busy    (busy),
    .cmd_end (cmd_end)
  );

  fpu_unpack u_unpack (
    .clk       (clk),
    .arst      (arst),
    .load      (load),
    .op_in     (op),
    .a_operand (a_operand),
    .b_operand (b_operand),
    .opnd      (u_opnd_if)
  );

  fpu_add_sub u_add_sub (
    .opnd       (u_opnd_if),
    .add_result (add_result)
  );

  fpu_mul u_mul (
    .opnd       (u_opnd_if),
    .mul_result (mul_result)
  );

  fpu_result_pack u_result_pack (
    .clk        (clk),
    .arst       (arst),
    .capture    (capture),
    .opnd       (u_opnd_if),
    .add_result (add_result),
    .mul_result (mul_result),
    .result     (result)
  );

endmodule

`default_nettype wire

/* bench/fpu_chk.sv */
// concurrent assertions on the command controller handshake
// bound into the fpu_cmd_ctrl module
`timescale 1ns/100ps
`default_nettype none

module fpu_chk (
  input logic                 clk,
  input logic                 arst,
  input logic                 start,
  input logic                 load,
  input logic                 capture,
  input logic                 busy,
  input logic                 cmd_end,
  input fpu_pkg::ctrl_state_t state
);

  // number of assertion failures so far
  int unsigned fail_count = 0;

  // end level only inside a command that was already running
  a_end_busy: assert property (@(posedge clk) disable iff (arst)
    cmd_end |-> busy && $past(busy))
    else begin
      fail_count++;
      $error("cmd_end high while not busy");
    end

  // operands are taken only by an idle engine, which then computes
  a_load_idle: assert property (@(posedge clk) disable iff (arst)
    load |-> !busy ##1 capture)
    else begin
      fail_count++;
      $error("load strobe while busy or not followed by capture");
    end

  // the captured result is presented in the next cycle
  a_capture_end: assert property (@(posedge clk) disable iff (arst) capture |=> cmd_end)
    else begin
      fail_count++;
      $error("cmd_end missing after capture");
    end

  // st_done is held as long as start stays high
  a_done_hold: assert property (@(posedge clk) disable iff (arst)
    (state == fpu_pkg::st_done && start) |=> (state == fpu_pkg::st_done))
    else begin
      fail_count++;
      $error("st_done left while start was high");
    end

endmodule

bind fpu_cmd_ctrl fpu_chk u_chk (
  .clk     (clk),
  .arst    (arst),
  .start   (start),
  .load    (load),
  .capture (capture),
  .busy    (busy),
  .cmd_end (cmd_end),
  .state   (state)
);

`default_nettype wire

/* bench/fpu_tb.sv */
// testbench of the fpu command engine
// reference models, compare tasks, directed tests for handshake, add, sub, mul
`timescale 1ns/100ps
`default_nettype none

module fpu_tb;

  logic             clk;
  logic             arst;
  logic             start;
  fpu_pkg::fpu_op_t op;
  fpu_pkg::word_t   a_operand;
  fpu_pkg::word_t   b_operand;
  fpu_pkg::word_t   result;
  logic             busy;
  logic             cmd_end;
  int               cycles;

  fpu_top u_fpu_top (
    .clk       (clk),
    .arst      (arst),
    .start     (start),
    .op        (op),
    .a_operand (a_operand),
    .b_operand (b_operand),
    .result    (result),
    .busy      (busy),
    .cmd_end   (cmd_end)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // run limit, the tests need roughly 450 cycles
  always @(posedge clk) begin
    cycles++;
    if (cycles >= 4000) begin
      $display("Timeout: the run did not finish within 4000 clock cycles");
      $display("Verification failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // add/sub model: align by truncation, signed sum, normalize
  function automatic fpu_pkg::word_t add_model(fpu_pkg::word_t a, fpu_pkg::word_t b,
                                               logic sub);
    longint ma;
    longint mb;
    longint s;
    longint m;
    int     ea;
    int     eb;
    int     e;
    logic   sg;
    ea = int'(a[30:23]);
    eb = int'(b[30:23]);
    ma = longint'(a[22:0]);
    mb = longint'(b[22:0]);
    // hidden bit only for a nonzero exponent
    if (ea != 0) ma = ma + 64'sh800000;
    if (eb != 0) mb = mb + 64'sh800000;
    e  = (ea > eb) ? ea : eb;
    ma = ma >> (e - ea);
    mb = mb >> (e - eb);
    if (a[31]) ma = -ma;
    // a - b is a plus b with its sign flipped
    if (b[31] ^ sub) mb = -mb;
    s  = ma + mb;
    sg = (s < 0);
    m  = sg ? -s : s;
    if (m == 0) return '0;
    if (m >= 64'sh1000000) begin
      m = m >> 1;
      e = e + 1;
    end
    while (m < 64'sh800000) begin
      m = m << 1;
      e = e - 1;
    end
    return {sg, e[7:0], m[22:0]};
  endfunction

  // multiply model: exact product, then round to nearest, ties to even
  function automatic fpu_pkg::word_t mul_model(fpu_pkg::word_t a, fpu_pkg::word_t b);
    longint p;
    longint m;
    longint rem;
    int     e;
    p = longint'({1'b1, a[22:0]}) * longint'({1'b1, b[22:0]});
    e = int'(a[30:23]) + int'(b[30:23]) - 127;
    // product of two normals lies in [1, 4), bring it to [2^47, 2^48)
    if (p >= 64'sh800000000000) e = e + 1;
    else p = p << 1;
    m   = p >> 24;
    rem = p & 64'shFFFFFF;
    if (rem > 64'sh800000 || (rem == 64'sh800000 && m[0])) m = m + 1;
    if (m == 64'sh1000000) begin
      m = m >> 1;
      e = e + 1;
    end
    return {a[31] ^ b[31], e[7:0], m[22:0]};
  endfunction

  function automatic fpu_pkg::word_t expect_of(fpu_pkg::fpu_op_t cmd, fpu_pkg::word_t a,
                                               fpu_pkg::word_t b);
    if (cmd == fpu_pkg::op_mul) return mul_model(a, b);
    return add_model(a, b, cmd == fpu_pkg::op_sub);
  endfunction

  // random normal number, exponent 100 to 154
  function automatic fpu_pkg::word_t rand_normal();
    logic [31:0] r;
    logic [7:0]  e;
    r = $urandom;
    e = 8'(100 + $urandom_range(54));
    return {r[31], e, r[22:0]};
  endfunction

  task automatic report_error(string line);
    $display("%s", line);
    $display("Verification failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(fpu_pkg::word_t got, fpu_pkg::word_t want, string what);
    if (got !== want) begin
      report_error($sformatf("Fail at %0t: %s result %h, expected %h", $time, what, got,
                             want));
    end
  endtask

  task automatic check_flag(logic got, logic want, string what);
    if (got !== want) begin
      report_error($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, want));
    end
  endtask

  // outputs are stable here and inputs change here
  task automatic step();
    @(posedge clk);
    #10;
  endtask

  // one full command: start, wait for cmd_end, check, release
  task automatic run_cmd(fpu_pkg::fpu_op_t cmd, fpu_pkg::word_t a, fpu_pkg::word_t b,
                         fpu_pkg::word_t want, string what);
    op        = cmd;
    a_operand = a;
    b_operand = b;
    start     = 1'b1;
    step();
    check_flag(busy, 1'b1, "busy after start");
    while (!cmd_end) step();
    check_word(result, want, what);
    start = 1'b0;
    step();
    check_flag(busy, 1'b0, "busy after release");
    check_flag(cmd_end, 1'b0, "cmd_end after release");
  endtask

  task automatic random_cmds(fpu_pkg::fpu_op_t cmd);
    fpu_pkg::word_t a;
    fpu_pkg::word_t b;
    repeat (40) begin
      a = rand_normal();
      b = rand_normal();
      run_cmd(cmd, a, b, expect_of(cmd, a, b), $sformatf("random %h %s %h", a, cmd.name(), b));
    end
  endtask

  task automatic test_reset();
    repeat (2) begin
      check_flag(busy, 1'b0, "busy after reset");
      check_flag(cmd_end, 1'b0, "cmd_end after reset");
      check_word(result, '0, "reset");
      step();
    end
  endtask

  task automatic test_handshake();
    op        = fpu_pkg::op_add;
    a_operand = 32'h3F800000;
    b_operand = 32'h3F800000;
    start     = 1'b1;
    step();
    check_flag(busy, 1'b1, "busy one cycle after start");
    check_flag(cmd_end, 1'b0, "cmd_end one cycle after start");
    step();
    check_flag(cmd_end, 1'b1, "cmd_end two cycles after start");
    check_word(result, 32'h40000000, "handshake 1.0 + 1.0");
    // new inputs while busy must not reach the result
    op        = fpu_pkg::op_mul;
    a_operand = 32'h40400000;
    b_operand = 32'hC0000000;
    repeat (4) begin
      step();
      check_flag(busy, 1'b1, "busy while start held");
      check_flag(cmd_end, 1'b1, "cmd_end while start held");
      check_word(result, 32'h40000000, "held command");
    end
    start = 1'b0;
    step();
    check_flag(busy, 1'b0, "busy one cycle after release");
    check_flag(cmd_end, 1'b0, "cmd_end one cycle after release");
    check_word(result, 32'h40000000, "result after release");
  endtask

  task automatic test_add();
    run_cmd(fpu_pkg::op_add, 32'h3F800000, 32'h3F800000, 32'h40000000, "1.0 + 1.0");
    run_cmd(fpu_pkg::op_add, 32'h3F800000, 32'h3F000000, 32'h3FC00000, "1.0 + 0.5");
    run_cmd(fpu_pkg::op_add, 32'h3FC00000, 32'h3FC00000, 32'h40400000, "1.5 + 1.5");
    run_cmd(fpu_pkg::op_add, 32'h40400000, 32'h00000000, 32'h40400000, "3.0 + 0");
    random_cmds(fpu_pkg::op_add);
  endtask

  task automatic test_sub();
    run_cmd(fpu_pkg::op_sub, 32'h3F800000, 32'h40400000, 32'hC0000000, "1.0 - 3.0");
    // left normalization by two and by four places
    run_cmd(fpu_pkg::op_sub, 32'h3FC00000, 32'h3FA00000, 32'h3E800000, "1.5 - 1.25");
    run_cmd(fpu_pkg::op_sub, 32'h3F800000, 32'h3F700000, 32'h3D800000, "1.0 - 0.9375");
    run_cmd(fpu_pkg::op_sub, 32'h40400000, 32'h40400000, 32'h00000000, "3.0 - 3.0");
    random_cmds(fpu_pkg::op_sub);
  endtask

  task automatic test_mul();
    run_cmd(fpu_pkg::op_mul, 32'h3FC00000, 32'h3FC00000, 32'h40100000, "1.5 * 1.5");
    run_cmd(fpu_pkg::op_mul, 32'h40000000, 32'h40400000, 32'h40C00000, "2.0 * 3.0");
    run_cmd(fpu_pkg::op_mul, 32'h3FC00000, 32'hC0000000, 32'hC0400000, "1.5 * -2.0");
    // dropped bits above half
    run_cmd(fpu_pkg::op_mul, 32'h3FC00001, 32'h3FC00000, 32'h40100001, "round up");
    // exact halves, odd lsb goes up, even lsb stays
    run_cmd(fpu_pkg::op_mul, 32'h3F800001, 32'h3FC00000, 32'h3FC00002, "tie to even up");
    run_cmd(fpu_pkg::op_mul, 32'h3F800003, 32'h3FC00000, 32'h3FC00004, "tie to even down");
    // all-ones mantissa rounds over to 2.0
    run_cmd(fpu_pkg::op_mul, 32'h3F918E00, 32'h3FE12000, 32'h40000000, "rounding carry");
    random_cmds(fpu_pkg::op_mul);
  endtask

  // start is low for a single edge between these commands
  task automatic test_back_to_back();
    run_cmd(fpu_pkg::op_add, 32'h3F800000, 32'h3F000000, 32'h3FC00000, "b2b add");
    run_cmd(fpu_pkg::op_mul, 32'h40000000, 32'h40400000, 32'h40C00000, "b2b mul");
    run_cmd(fpu_pkg::op_sub, 32'h3FC00000, 32'h3FA00000, 32'h3E800000, "b2b sub");
  endtask

  initial begin
    cycles    = 0;
    arst      = 1'b1;
    start     = 1'b0;
    op        = fpu_pkg::op_add;
    a_operand = '0;
    b_operand = '0;
    void'($urandom(32'h7608a1cd));
    repeat (2) @(posedge clk);
    #10;
    arst = 1'b0;
    test_reset();
    test_handshake();
    test_add();
    test_sub();
    test_mul();
    test_back_to_back();
    if (u_fpu_top.u_cmd_ctrl.u_chk.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
logic/fpu_pkg.sv
logic/fpu_operand_if.sv
logic/fpu_cmd_ctrl.sv
logic/fpu_unpack.sv
logic/fpu_add_sub.sv
logic/fpu_mul.sv
logic/fpu_result_pack.sv
logic/fpu_top.sv
bench/fpu_chk.sv
bench/fpu_tb.sv

/* Makefile */
# Verilator build and run of the fpu testbench

VERILATOR ?= verilator
TOP       ?= fpu_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
